// ==== common/vgaPkg.sv ====
// Shared definitions for the VGA display subsystem
//   Field widths for coordinates and colour channels
//   640x480 timing constants, horizontal and vertical
//   coord_t and rgb_t types
//   Register address map and CTRL bit positions

package vgaPkg;

    //----------------------------------------------------------------------
    // Field widths
    //----------------------------------------------------------------------
    localparam int COORD_WIDTH = 10;               // Pixel and line counters
    localparam int CHAN_WIDTH  = 4;                // One colour channel
    localparam int RGB_WIDTH   = 3 * CHAN_WIDTH;   // Packed red, green, blue
    localparam int REG_WIDTH   = 16;               // Register write data

    typedef logic [COORD_WIDTH-1:0] coord_t;

    typedef struct packed {
        logic [CHAN_WIDTH-1:0] red;     // Upper nibble in a colour write
        logic [CHAN_WIDTH-1:0] green;
        logic [CHAN_WIDTH-1:0] blue;    // Lower nibble
    } rgb_t;

    //----------------------------------------------------------------------
    // 640x480 timing, counts start at 0 and end values are exclusive
    //----------------------------------------------------------------------
    localparam coord_t H_ACTIVE     = 10'd640;   // Visible pixels per line
    localparam coord_t H_SYNC_START = 10'd656;   // After 16 pixel front porch
    localparam coord_t H_SYNC_END   = 10'd752;   // 96 pixel sync pulse
    localparam coord_t H_TOTAL      = 10'd800;   // Pixels per line incl. blanking

    localparam coord_t V_ACTIVE     = 10'd480;   // Visible lines
    localparam coord_t V_SYNC_START = 10'd490;   // After 10 line front porch
    localparam coord_t V_SYNC_END   = 10'd492;   // Two line sync pulse
    localparam coord_t V_TOTAL      = 10'd525;   // Lines per frame

    // Register map, address 7 is unmapped
    typedef enum logic [2:0] {
        CTRL      = 3'd0,
        BG_COLOR  = 3'd1,
        BOX_X     = 3'd2,
        BOX_Y     = 3'd3,
        BOX_W     = 3'd4,
        BOX_H     = 3'd5,
        BOX_COLOR = 3'd6
    } regAddr_t;

    // CTRL register bits
    localparam int CTRL_SOFT_RESET = 0;   // Write 1 to restart the counters
    localparam int CTRL_DISPLAY_EN = 1;   // 0 forces black output

endpackage

// ==== common/vgaCfgIf.sv ====
// Configuration bundle from the register block to the pixel generator
//   Background colour, box geometry and colour, display enable
//   regs modport drives, gen modport reads

interface vgaCfgIf;
    import vgaPkg::*;

    rgb_t   bgColor;        // Colour outside the box
    coord_t boxX;           // Box left edge
    coord_t boxY;           // Box top edge
    coord_t boxW;           // Width in pixels, 0 gives no box
    coord_t boxH;           // Height in lines
    rgb_t   boxColor;
    logic   displayEnable;  // Low blacks out the picture

    // Register side owns the values
    modport regs (
        output bgColor, boxX, boxY, boxW, boxH, boxColor, displayEnable
    );

    // Pixel side only looks at them
    modport gen (
        input bgColor, boxX, boxY, boxW, boxH, boxColor, displayEnable
    );

endinterface

// ==== vga/vgaTiming.sv ====
// 640x480 VGA timing generator
//   Pixel clock at half the system clock, used as a count enable
//   800 x 525 horizontal and vertical counters
//   Registered active-low syncs aligned with the coordinates
//   Active-area level from the current counters

module vgaTiming (
    input  logic          Clk,
    input  logic          Reset,        // Asynchronous, active high
    input  logic          softReset,    // One cycle pulse from the register block
    output logic          pixelClk,     // Clk / 2
    output logic          hSync,        // Active low
    output logic          vSync,        // Active low
    output logic          display,      // High inside the 640x480 area
    output vgaPkg::coord_t drawX,       // Current pixel in the line
    output vgaPkg::coord_t drawY        // Current line in the frame
);
    import vgaPkg::*;

    logic   pixelAdvance;   // Counters step on this Clk edge
    logic   lastPixel;      // drawX at 799
    logic   lastLine;       // drawY at 524
    coord_t nextX;
    coord_t nextY;
    logic   hSyncNext;
    logic   vSyncNext;

    //----------------------------------------------------------------------
    // Pixel clock divider
    //----------------------------------------------------------------------
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            pixelClk <= 1'b0;
        else if (softReset)
            pixelClk <= 1'b0;       // Restart the phase with the counters
        else
            pixelClk <= ~pixelClk;
    end

    // Step on the edge where pixelClk rises, so each count holds two Clk cycles
    assign pixelAdvance = ~pixelClk;

    //----------------------------------------------------------------------
    // Next count
    //----------------------------------------------------------------------
    assign lastPixel = (drawX == H_TOTAL - 1'b1);
    assign lastLine  = (drawY == V_TOTAL - 1'b1);

    always_comb
    begin
        nextX = drawX + 1'b1;
        nextY = drawY;
        if (lastPixel)
        begin
            nextX = '0;
            if (lastLine)
                nextY = '0;             // Frame wrap
            else
                nextY = drawY + 1'b1;   // Line wrap moves down one line
        end
    end

    // Sync decode on the next count so the register lines up with drawX/drawY
    assign hSyncNext = ~((nextX >= H_SYNC_START) && (nextX < H_SYNC_END));
    assign vSyncNext = ~((nextY >= V_SYNC_START) && (nextY < V_SYNC_END));

    //----------------------------------------------------------------------
    // Counters and syncs
    //----------------------------------------------------------------------
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            drawX <= '0;
            drawY <= '0;
            hSync <= 1'b1;      // Inactive
            vSync <= 1'b1;
        end
        else if (softReset)
        begin
            // Same state as after Reset
            drawX <= '0;
            drawY <= '0;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end
        else if (pixelAdvance)
        begin
            drawX <= nextX;
            drawY <= nextY;
            hSync <= hSyncNext;   // Low for drawX 656..751
            vSync <= vSyncNext;   // Low for lines 490 and 491
        end
    end

    // Visible area, combinational from the counters
    assign display = (drawX < H_ACTIVE) && (drawY < V_ACTIVE);

endmodule

// ==== vga/vgaRegs.sv ====
// Write-only configuration registers
//   Address decode for the seven registers of the map
//   Field truncation to coordinate and colour widths
//   Self-clearing software reset pulse from CTRL bit 0

module vgaRegs (
    input  logic                         Clk,
    input  logic                         Reset,
    input  vgaPkg::regAddr_t             regAddr,
    input  logic [vgaPkg::REG_WIDTH-1:0] regWrData,
    input  logic                         regWrEn,     // Write strobe, one Clk per write
    output logic                         softReset,   // Registered one cycle pulse
    vgaCfgIf.regs                        cfg
);
    import vgaPkg::*;

    logic   ctrlWrite;      // CTRL addressed this cycle
    coord_t wrCoord;        // Write data cut to coordinate width
    rgb_t   wrColor;        // Write data cut to colour width

    assign ctrlWrite = regWrEn && (regAddr == CTRL);
    assign wrCoord   = regWrData[COORD_WIDTH-1:0];
    assign wrColor   = rgb_t'(regWrData[RGB_WIDTH-1:0]);   // [11:8] red ... [3:0] blue

    //----------------------------------------------------------------------
    // Software reset
    //----------------------------------------------------------------------
    // Only ever a pulse, bit 0 is not kept as a level
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            softReset <= 1'b0;
        else
            softReset <= ctrlWrite && regWrData[CTRL_SOFT_RESET];
    end

    //----------------------------------------------------------------------
    // Configuration registers
    //----------------------------------------------------------------------
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            cfg.displayEnable <= 1'b1;   // Output on by default
            cfg.bgColor       <= '0;     // Black
            cfg.boxX          <= '0;
            cfg.boxY          <= '0;
            cfg.boxW          <= '0;     // Empty box
            cfg.boxH          <= '0;
            cfg.boxColor      <= '0;
        end
        else if (regWrEn)
        begin
            case (regAddr)
                CTRL:      cfg.displayEnable <= regWrData[CTRL_DISPLAY_EN];
                BG_COLOR:  cfg.bgColor       <= wrColor;
                BOX_X:     cfg.boxX          <= wrCoord;
                BOX_Y:     cfg.boxY          <= wrCoord;
                BOX_W:     cfg.boxW          <= wrCoord;
                BOX_H:     cfg.boxH          <= wrCoord;
                BOX_COLOR: cfg.boxColor      <= wrColor;
                default:
                begin
                    // Unmapped address, write is dropped
                end
            endcase
        end
    end

endmodule

// ==== src/pixelGenerator.sv ====
// Pixel colour selection
//   Box hit test against the current coordinates
//   Background, box or black, purely combinational

module pixelGenerator (
    input  vgaPkg::coord_t                drawX,
    input  vgaPkg::coord_t                drawY,
    input  logic                          display,   // High in the visible area
    vgaCfgIf.gen                          cfg,
    output logic [vgaPkg::CHAN_WIDTH-1:0] red,
    output logic [vgaPkg::CHAN_WIDTH-1:0] green,
    output logic [vgaPkg::CHAN_WIDTH-1:0] blue
);
    import vgaPkg::*;

    // One extra bit so a box past the right or bottom edge does not wrap
    logic [COORD_WIDTH:0] boxRight;    // First column after the box
    logic [COORD_WIDTH:0] boxBottom;   // First line after the box
    logic                 insideX;
    logic                 insideY;
    logic                 showPixel;
    rgb_t                 pixel;

    assign boxRight  = {1'b0, cfg.boxX} + {1'b0, cfg.boxW};
    assign boxBottom = {1'b0, cfg.boxY} + {1'b0, cfg.boxH};

    // Left and top edges inclusive, right and bottom exclusive
    assign insideX = (drawX >= cfg.boxX) && ({1'b0, drawX} < boxRight);
    assign insideY = (drawY >= cfg.boxY) && ({1'b0, drawY} < boxBottom);

    assign showPixel = display && cfg.displayEnable;

    //----------------------------------------------------------------------
    // Colour mux
    //----------------------------------------------------------------------
    always_comb
    begin
        if (!showPixel)
            pixel = '0;                 // Blanking or display off
        else if (insideX && insideY)
            pixel = cfg.boxColor;
        else
            pixel = cfg.bgColor;
    end

    assign red   = pixel.red;
    assign green = pixel.green;
    assign blue  = pixel.blue;

endmodule

// ==== src/vgaSubsystem.sv ====
// VGA display subsystem top level
//   Register block, timing generator and pixel generator
//   Configuration bundle between registers and pixel generator
//   Plain ports toward the board and the host

module vgaSubsystem (
    input  logic        Clk,
    input  logic        Reset,       // Asynchronous, active high
    input  logic [2:0]  regAddr,     // Register address, 7 is ignored
    input  logic [15:0] regWrData,
    input  logic        regWrEn,     // Write strobe
    output logic        hSync,       // Active low
    output logic        vSync,       // Active low
    output logic        pixelClk,    // Clk / 2
    output logic        blank,       // High in the visible area
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    output logic [9:0]  drawX,
    output logic [9:0]  drawY
);
    import vgaPkg::*;

    logic softReset;   // Pulse from CTRL bit 0 to the timing block
    logic display;     // Visible area from the timing block

    vgaCfgIf cfgBus ();

    //----------------------------------------------------------------------
    // Blocks
    //----------------------------------------------------------------------
    vgaRegs i_regs (
        .Clk       (Clk),
        .Reset     (Reset),
        .regAddr   (regAddr_t'(regAddr)),
        .regWrData (regWrData),
        .regWrEn   (regWrEn),
        .softReset (softReset),
        .cfg       (cfgBus.regs)
    );

    vgaTiming i_timing (
        .Clk       (Clk),
        .Reset     (Reset),
        .softReset (softReset),
        .pixelClk  (pixelClk),
        .hSync     (hSync),
        .vSync     (vSync),
        .display   (display),
        .drawX     (drawX),
        .drawY     (drawY)
    );

    pixelGenerator i_pixel (
        .drawX   (drawX),
        .drawY   (drawY),
        .display (display),
        .cfg     (cfgBus.gen),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    assign blank = display;

endmodule

// ==== tb/vgaSubsystemTb.sv ====
// Directed testbench for the VGA display subsystem
//   Clock, reset and falling-edge register writes
//   Sampling once per pixel, on falling edges with pixelClk high
//   Compare tasks for coordinates, colours and single bits
//   Six tests, cycle-count timeout and closing summary

module vgaSubsystemTb;
    import vgaPkg::*;

    localparam int   FRAME_CYCLES   = 2 * 800 * 525;   // Two Clk cycles per pixel
    localparam int   TIMEOUT_CYCLES = 4_000_000;       // About 4.75 frames, tests need ~4
    localparam rgb_t BLACK          = '0;

    logic        Clk;
    logic        Reset;
    logic [2:0]  regAddr;
    logic [15:0] regWrData;
    logic        regWrEn;
    logic        hSync;
    logic        vSync;
    logic        pixelClk;
    logic        blank;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    coord_t      drawX;
    coord_t      drawY;

    int     cycleCount  = 0;
    int     errorCount  = 0;   // All failed checks
    int     testErrors  = 0;   // Failed checks in the running test
    int     testsRun    = 0;
    int     failedTests = 0;
    string  currentTest;

    // Random box setup from test 4, reused by tests 5 and 6
    coord_t boxLeft;
    coord_t boxTop;
    coord_t boxWidth;
    coord_t boxHeight;
    rgb_t   bgRand;
    rgb_t   boxRand;

    vgaSubsystem i_dut (
        .Clk       (Clk),
        .Reset     (Reset),
        .regAddr   (regAddr),
        .regWrData (regWrData),
        .regWrEn   (regWrEn),
        .hSync     (hSync),
        .vSync     (vSync),
        .pixelClk  (pixelClk),
        .blank     (blank),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .drawX     (drawX),
        .drawY     (drawY)
    );

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;   // Period 8
    end

    // Run limit
    always @(posedge Clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Reference rules for the timing outputs
    // ----------------------------------------------------------------------
    function automatic logic expectedHSync(input coord_t x);
        return !((x >= 10'd656) && (x <= 10'd751));   // Low 656..751
    endfunction

    function automatic logic expectedVSync(input coord_t y);
        return !((y == 10'd490) || (y == 10'd491));   // Low on 490, 491
    endfunction

    function automatic logic expectedBlank(input coord_t x, input coord_t y);
        return (x < 10'd640) && (y < 10'd480);        // High in the 640x480 picture
    endfunction

    function automatic rgb_t outputColor();
        rgb_t c;
        c.red   = red;
        c.green = green;
        c.blue  = blue;
        return c;
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic checkCoord(input string what, input coord_t expected, input coord_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s %s: expected %0d, actual %0d",
                     currentTest, what, expected, actual);
            errorCount = errorCount + 1;
            testErrors = testErrors + 1;
        end
    endtask

    task automatic checkColor(input string what, input rgb_t expected, input rgb_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s %s: expected %03h, actual %03h",
                     currentTest, what, expected, actual);
            errorCount = errorCount + 1;
            testErrors = testErrors + 1;
        end
    endtask

    task automatic checkBit(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s %s: expected %0b, actual %0b",
                     currentTest, what, expected, actual);
            errorCount = errorCount + 1;
            testErrors = testErrors + 1;
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and sampling helpers
    // ----------------------------------------------------------------------
    task automatic writeReg(input regAddr_t addr, input logic [15:0] data);
        @(negedge Clk);
        regAddr   = addr;
        regWrData = data;
        regWrEn   = 1'b1;
        @(negedge Clk);
        regWrEn   = 1'b0;      // Single Clk strobe
    endtask

    // One sample per pixel, outputs settled at the falling edge
    task automatic nextSample();
        @(negedge Clk);
        while (pixelClk !== 1'b1)
            @(negedge Clk);
    endtask

    task automatic waitPixel(input coord_t x, input coord_t y);
        nextSample();
        while ((drawX !== x) || (drawY !== y))
            nextSample();
    endtask

    task automatic checkPoint(input string what, input coord_t x, input coord_t y,
                              input rgb_t expected);
        waitPixel(x, y);
        checkColor(what, expected, outputColor());
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        testErrors  = 0;
    endtask

    task automatic endTest();
        testsRun = testsRun + 1;
        if (testErrors == 0)
            $display("%s: ok", currentTest);
        else
        begin
            $display("%s: %0d failed checks", currentTest, testErrors);
            failedTests = failedTests + 1;
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic resetState();
        startTest("resetState");
        checkCoord("drawX", 10'd0, drawX);
        checkCoord("drawY", 10'd0, drawY);
        checkBit("hSync", 1'b1, hSync);
        checkBit("vSync", 1'b1, vSync);
        checkBit("pixelClk", 1'b0, pixelClk);
        checkColor("colour", BLACK, outputColor());   // Background resets to black
        endTest();
    endtask

    task automatic horizontalTiming();
        coord_t expX;
        startTest("horizontalTiming");
        waitPixel(10'd0, 10'd1);
        expX = 10'd0;
        repeat (800)
        begin
            checkCoord("drawX", expX, drawX);
            checkBit("hSync", expectedHSync(expX), hSync);
            checkBit("blank", expectedBlank(expX, 10'd1), blank);
            expX = expX + 10'd1;
            nextSample();
        end
        checkCoord("drawX after wrap", 10'd0, drawX);   // 799 -> 0
        checkCoord("drawY after wrap", 10'd2, drawY);
        endTest();
    endtask

    task automatic verticalTiming();
        coord_t expY;
        startTest("verticalTiming");
        expY = 10'd2;                       // Left at the start of line 2
        repeat (526)                        // One frame plus the 524 -> 0 wrap
        begin
            checkCoord("drawX", 10'd0, drawX);
            checkCoord("drawY", expY, drawY);
            checkBit("vSync", expectedVSync(expY), vSync);
            checkBit("blank", expectedBlank(10'd0, expY), blank);
            repeat (800)
                nextSample();               // Exactly one line
            expY = (expY == 10'd524) ? 10'd0 : expY + 10'd1;
        end
        endTest();
    endtask

    task automatic boxColors();
        logic [11:0] rnd;
        startTest("boxColors");
        boxLeft   = 10'($urandom_range(500, 1));
        boxTop    = 10'($urandom_range(380, 8));
        boxWidth  = 10'($urandom_range(120, 20));   // Right edge stays below 640
        boxHeight = 10'($urandom_range(90, 10));    // Bottom edge stays below 480
        rnd       = 12'($urandom_range(4095, 0));
        bgRand    = rgb_t'(rnd);
        rnd       = 12'($urandom_range(4095, 0));
        boxRand   = rgb_t'(rnd);

        writeReg(BG_COLOR, {4'h0, bgRand});
        writeReg(BOX_X, {6'd0, boxLeft});
        writeReg(BOX_Y, {6'd0, boxTop});
        writeReg(BOX_W, {6'd0, boxWidth});
        writeReg(BOX_H, {6'd0, boxHeight});
        writeReg(BOX_COLOR, {4'h0, boxRand});

        // Raster order, so all points fall in one frame
        checkPoint("above top edge", boxLeft, boxTop - 10'd1, bgRand);
        checkPoint("left of box", boxLeft - 10'd1, boxTop, bgRand);
        checkPoint("top left corner", boxLeft, boxTop, boxRand);
        checkPoint("top right corner", boxLeft + boxWidth - 10'd1, boxTop, boxRand);
        checkPoint("right of box", boxLeft + boxWidth, boxTop, bgRand);
        checkPoint("horizontal blanking", 10'd700, boxTop, BLACK);
        checkPoint("box centre", boxLeft + (boxWidth >> 1), boxTop + (boxHeight >> 1),
                   boxRand);
        checkPoint("bottom left corner", boxLeft, boxTop + boxHeight - 10'd1, boxRand);
        checkPoint("below box", boxLeft + boxWidth - 10'd1, boxTop + boxHeight, bgRand);
        checkPoint("vertical blanking", 10'd100, 10'd500, BLACK);
        endTest();
    endtask

    task automatic softResetRestart();
        startTest("softResetRestart");
        waitPixel(10'd700, 10'd491);        // Inside both sync pulses
        writeReg(CTRL, 16'h0003);           // Soft reset, display stays on
        @(negedge Clk);                     // Pulse has cleared the timing state
        checkCoord("drawX", 10'd0, drawX);
        checkCoord("drawY", 10'd0, drawY);
        checkBit("pixelClk", 1'b0, pixelClk);
        checkBit("hSync", 1'b1, hSync);
        checkBit("vSync", 1'b1, vSync);
        nextSample();
        checkCoord("first drawX", 10'd1, drawX);
        checkCoord("first drawY", 10'd0, drawY);
        nextSample();
        checkCoord("second drawX", 10'd2, drawX);
        // Configuration survives the restart
        checkPoint("left of box", boxLeft - 10'd1, boxTop, bgRand);
        checkPoint("top left corner", boxLeft, boxTop, boxRand);
        endTest();
    endtask

    task automatic displayDisable();
        coord_t lineY;
        coord_t expX;
        startTest("displayDisable");
        writeReg(CTRL, 16'h0000);           // Display off, no soft reset
        checkPoint("box centre", boxLeft + (boxWidth >> 1), boxTop + (boxHeight >> 1),
                   BLACK);
        lineY = boxTop + boxHeight - 10'd1;   // Line through the box
        waitPixel(10'd0, lineY);
        expX = 10'd0;
        repeat (800)
        begin
            checkColor("colour", BLACK, outputColor());
            checkBit("hSync", expectedHSync(expX), hSync);
            expX = expX + 10'd1;
            nextSample();
        end
        waitPixel(10'd0, 10'd489);
        checkBit("vSync line 489", 1'b1, vSync);
        waitPixel(10'd0, 10'd490);
        checkBit("vSync line 490", 1'b0, vSync);
        waitPixel(10'd0, 10'd491);
        checkBit("vSync line 491", 1'b0, vSync);
        waitPixel(10'd0, 10'd492);
        checkBit("vSync line 492", 1'b1, vSync);
        endTest();
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial
    begin
        Reset     = 1'b1;
        regAddr   = 3'd0;
        regWrData = 16'h0000;
        regWrEn   = 1'b0;
        void'($urandom(28474));   // Seed the random stream once

        repeat (10)
            @(negedge Clk);
        Reset = 1'b0;

        resetState();
        horizontalTiming();
        verticalTiming();
        boxColors();
        softResetRestart();
        displayDisable();

        $display("Tests: %0d run, %0d failed, %0d failed checks, %0d of %0d frame cycles",
                 testsRun, failedTests, errorCount, cycleCount, FRAME_CYCLES);
        if ((errorCount == 0) && (failedTests == 0))
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== vgaSubsystem.f ====
common/vgaPkg.sv
common/vgaCfgIf.sv
vga/vgaTiming.sv
vga/vgaRegs.sv
src/pixelGenerator.sv
src/vgaSubsystem.sv
tb/vgaSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the VGA subsystem testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --top-module vgaSubsystemTb -f vgaSubsystem.f \
    -o vgaSubsystemSim > build.log 2>&1 \
    && ./obj_dir/vgaSubsystemSim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
